//--- logic/cpu_core_pkg.sv
// Kept 6809 subset only; direct page is fixed at zero and no X, Y, U, S or 16-bit forms exist
`default_nettype none

package cpu_core_pkg;

  // ----------------------------------------
  // Basic words
  // ----------------------------------------
  typedef logic [15:0] addr_t;
  typedef logic [7:0]  byte_t;

  // Condition codes, E in the top bit
  typedef struct packed {
    logic e;
    logic f;
    logic h;
    logic i;
    logic n;
    logic z;
    logic v;
    logic c;
  } cc_t;

  // E, F and I set out of reset
  localparam cc_t   CC_RESET    = 8'hD0;
  // No DP register, so direct mode always hits page zero
  localparam byte_t DIRECT_PAGE = 8'h00;

  // One-hot fetch states
  typedef enum logic [4:0] {
    fetch_wait    = 5'b0_0001,
    fetch_ir      = 5'b0_0010,
    fetch_operand = 5'b0_0100,
    fetch_store   = 5'b0_1000
  } fetch_state_e;

  // ----------------------------------------
  // Pipeline payloads
  // ----------------------------------------
  // Completed instruction, operand zero for one-byte forms
  typedef struct packed {
    logic  valid;
    byte_t opcode;
    byte_t operand;
  } inst_t;

  // Direct-mode write, offset is the low address byte
  typedef struct packed {
    logic  valid;
    logic  src_b;
    byte_t offset;
  } store_req_t;

  typedef struct packed {
    byte_t value;
    logic  h;
    logic  n;
    logic  z;
    logic  v;
    logic  c;
  } alu_result_t;

  // ----------------------------------------
  // Opcode rows (high nibble)
  // ----------------------------------------
  localparam logic [3:0] ROW_BRANCH = 4'h2;
  localparam logic [3:0] ROW_INH_A  = 4'h4;
  localparam logic [3:0] ROW_INH_B  = 4'h5;
  localparam logic [3:0] ROW_IMM_A  = 4'h8;
  localparam logic [3:0] ROW_IMM_B  = 4'hC;

  localparam byte_t OP_STA_DIR = 8'h97;
  localparam byte_t OP_STB_DIR = 8'hD7;

  // Immediate columns, rows 8 and C
  localparam logic [3:0] COL_SUB = 4'h0;
  localparam logic [3:0] COL_CMP = 4'h1;
  localparam logic [3:0] COL_SBC = 4'h2;
  localparam logic [3:0] COL_AND = 4'h4;
  localparam logic [3:0] COL_BIT = 4'h5;
  localparam logic [3:0] COL_LD  = 4'h6;
  localparam logic [3:0] COL_EOR = 4'h8;
  localparam logic [3:0] COL_ADC = 4'h9;
  localparam logic [3:0] COL_OR  = 4'hA;
  localparam logic [3:0] COL_ADD = 4'hB;

  // Inherent columns, rows 4 and 5
  localparam logic [3:0] COL_NEG = 4'h0;
  localparam logic [3:0] COL_COM = 4'h3;
  localparam logic [3:0] COL_LSR = 4'h4;
  localparam logic [3:0] COL_ROR = 4'h6;
  localparam logic [3:0] COL_ASR = 4'h7;
  localparam logic [3:0] COL_ASL = 4'h8;
  localparam logic [3:0] COL_ROL = 4'h9;
  localparam logic [3:0] COL_DEC = 4'hA;
  localparam logic [3:0] COL_INC = 4'hC;
  localparam logic [3:0] COL_TST = 4'hD;
  localparam logic [3:0] COL_CLR = 4'hF;

endpackage

`default_nettype wire

//--- logic/alu8.sv
// Unkept columns pass lhs and the input flags through; H changes only on ADD and ADC
`default_nettype none

module alu8 import cpu_core_pkg::*; (
  input  byte_t       lhs,
  input  byte_t       rhs,
  input  logic [3:0]  op_col,
  input  logic        inherent,
  input  cc_t         cc_in,
  output alu_result_t result
);

  logic [8:0] add_sum;
  logic [8:0] sub_diff;
  byte_t      sub_lhs;
  byte_t      sub_rhs;
  logic       add_cin;
  logic       sub_bin;
  logic       kept;

  // ----------------------------------------
  // Shared adder and subtractor
  // ----------------------------------------
  assign add_cin = (op_col == COL_ADC) && cc_in.c;
  assign sub_bin = !inherent && (op_col == COL_SBC) && cc_in.c;

  // NEG is zero minus lhs
  assign sub_lhs = inherent ? 8'h00 : lhs;
  assign sub_rhs = inherent ? lhs : rhs;

  assign add_sum  = {1'b0, lhs} + {1'b0, rhs} + {8'h00, add_cin};
  assign sub_diff = {1'b0, sub_lhs} - {1'b0, sub_rhs} - {8'h00, sub_bin};

  always_comb begin
    result.value = lhs;
    result.h     = cc_in.h;
    result.n     = cc_in.n;
    result.z     = cc_in.z;
    result.v     = cc_in.v;
    result.c     = cc_in.c;
    kept         = 1'b1;
    if (!inherent) begin
      case (op_col)
        COL_SUB, COL_CMP, COL_SBC: begin
          result.value = sub_diff[7:0];
          result.v     = (sub_lhs[7] ^ sub_rhs[7]) & (sub_lhs[7] ^ sub_diff[7]);
          result.c     = sub_diff[8];
        end
        COL_AND, COL_BIT: begin
          result.value = lhs & rhs;
          result.v     = 1'b0;
        end
        COL_LD: begin
          result.value = rhs;
          result.v     = 1'b0;
        end
        COL_EOR: begin
          result.value = lhs ^ rhs;
          result.v     = 1'b0;
        end
        COL_OR: begin
          result.value = lhs | rhs;
          result.v     = 1'b0;
        end
        COL_ADC, COL_ADD: begin
          result.value = add_sum[7:0];
          // Carry into bit 4
          result.h     = lhs[4] ^ rhs[4] ^ add_sum[4];
          result.v     = (lhs[7] ~^ rhs[7]) & (lhs[7] ^ add_sum[7]);
          result.c     = add_sum[8];
        end
        default: kept = 1'b0;
      endcase
    end else begin
      case (op_col)
        COL_NEG: begin
          result.value = sub_diff[7:0];
          result.v     = sub_rhs[7] & sub_diff[7];
          result.c     = sub_diff[8];
        end
        COL_COM: begin
          result.value = ~lhs;
          result.v     = 1'b0;
          result.c     = 1'b1;
        end
        // Right shifts leave V alone
        COL_LSR: begin
          result.value = {1'b0, lhs[7:1]};
          result.c     = lhs[0];
        end
        COL_ROR: begin
          result.value = {cc_in.c, lhs[7:1]};
          result.c     = lhs[0];
        end
        COL_ASR: begin
          result.value = {lhs[7], lhs[7:1]};
          result.c     = lhs[0];
        end
        // Left shifts, V is N xor C
        COL_ASL, COL_ROL: begin
          result.value = {lhs[6:0], (op_col == COL_ROL) & cc_in.c};
          result.v     = lhs[7] ^ lhs[6];
          result.c     = lhs[7];
        end
        COL_DEC: begin
          result.value = lhs - 8'd1;
          result.v     = (lhs == 8'h80);
        end
        COL_INC: begin
          result.value = lhs + 8'd1;
          result.v     = (lhs == 8'h7F);
        end
        COL_TST: result.v = 1'b0;
        COL_CLR: begin
          result.value = 8'h00;
          result.v     = 1'b0;
          result.c     = 1'b0;
        end
        default: kept = 1'b0;
      endcase
    end
    // N and Z always follow the value
    if (kept) begin
      result.n = result.value[7];
      result.z = (result.value == 8'h00);
    end
  end

endmodule

`default_nettype wire

//--- logic/register_file.sv
// Only A, B and CC are held; E, F and I never change after reset
`default_nettype none

module register_file import cpu_core_pkg::*; (
  input  logic  clk,
  input  logic  reset_b,
  input  inst_t inst,
  output byte_t a_q,
  output byte_t b_q,
  output cc_t   cc
);

  logic [3:0]  row;
  logic [3:0]  col;
  logic [3:0]  alu_col;
  logic        is_store;
  logic        is_imm;
  logic        is_inh;
  logic        use_b;
  logic        kept;
  logic        write_back;
  byte_t       lhs;
  byte_t       rhs;
  alu_result_t alu_out;

  // ----------------------------------------
  // Decode
  // ----------------------------------------
  assign row      = inst.opcode[7:4];
  assign col      = inst.opcode[3:0];
  assign is_store = (inst.opcode == OP_STA_DIR) || (inst.opcode == OP_STB_DIR);
  assign is_imm   = (row == ROW_IMM_A) || (row == ROW_IMM_B);
  assign is_inh   = (row == ROW_INH_A) || (row == ROW_INH_B);
  assign use_b    = (row == ROW_IMM_B) || (row == ROW_INH_B) || (inst.opcode == OP_STB_DIR);

  always_comb begin
    if (is_store) begin
      kept = 1'b1;
    end else if (is_imm) begin
      kept = col inside {COL_SUB, COL_CMP, COL_SBC, COL_AND, COL_BIT,
                         COL_LD, COL_EOR, COL_ADC, COL_OR, COL_ADD};
    end else if (is_inh) begin
      kept = col inside {COL_NEG, COL_COM, COL_LSR, COL_ROR, COL_ASR, COL_ASL,
                         COL_ROL, COL_DEC, COL_INC, COL_TST, COL_CLR};
    end else begin
      kept = 1'b0;
    end
  end

  // Compares and tests only touch flags
  assign write_back = kept && !is_store &&
                      !(is_imm && ((col == COL_CMP) || (col == COL_BIT))) &&
                      !(is_inh && (col == COL_TST));

  // Store flags are those of a load of the same register
  assign lhs     = use_b ? b_q : a_q;
  assign rhs     = is_store ? lhs : inst.operand;
  assign alu_col = is_store ? COL_LD : col;

  alu8 u_alu8 (
    .lhs     (lhs),
    .rhs     (rhs),
    .op_col  (alu_col),
    .inherent(is_inh),
    .cc_in   (cc),
    .result  (alu_out)
  );

  // ----------------------------------------
  // Write-back
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      a_q <= 8'h00;
      b_q <= 8'h00;
      cc  <= CC_RESET;
    end else if (inst.valid) begin
      if (write_back && !use_b) begin
        a_q <= alu_out.value;
      end
      if (write_back && use_b) begin
        b_q <= alu_out.value;
      end
      if (kept) begin
        cc.h <= alu_out.h;
        cc.n <= alu_out.n;
        cc.z <= alu_out.z;
        cc.v <= alu_out.v;
        cc.c <= alu_out.c;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/load_store_unit.sv
// Vector is read big-endian once after reset; stores are single direct-page writes, no loads
`default_nettype none

module load_store_unit import cpu_core_pkg::*; #(
  parameter addr_t VECTOR_ADDR = 16'hFFFE
) (
  input  logic       clk,
  input  logic       reset_b,
  input  byte_t      din,
  input  store_req_t store_req,
  input  byte_t      a_q,
  input  byte_t      b_q,
  output logic       bus_busy,
  output addr_t      lsu_addr,
  output logic       vector_valid,
  output addr_t      vector,
  output logic       data_rw_n,
  output byte_t      data_out
);

  typedef enum logic [1:0] {
    lsu_load_high,
    lsu_load_low,
    lsu_idle
  } lsu_state_e;

  lsu_state_e state;
  // Staged high vector byte
  byte_t      vector_hi;
  logic       store_cycle;

  // Write only when idle and fetch asks for it
  assign store_cycle = (state == lsu_idle) && store_req.valid;

  // Bus is ours while loading the vector or writing
  assign bus_busy = (state != lsu_idle) || store_cycle;

  always_comb begin
    case (state)
      lsu_load_high: lsu_addr = VECTOR_ADDR;
      lsu_load_low:  lsu_addr = VECTOR_ADDR + 16'd1;
      default:       lsu_addr = {DIRECT_PAGE, store_req.offset};
    endcase
  end

  // Low byte comes straight off the bus
  assign vector_valid = (state == lsu_load_low);
  assign vector       = {vector_hi, din};

  assign data_rw_n = ~store_cycle;
  assign data_out  = store_req.src_b ? b_q : a_q;

  // ----------------------------------------
  // Vector load sequence
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      state <= lsu_load_high;
    end else begin
      case (state)
        lsu_load_high: state <= lsu_load_low;
        lsu_load_low:  state <= lsu_idle;
        default:       state <= lsu_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == lsu_load_high) begin
      vector_hi <= din;
    end
  end

endmodule

`default_nettype wire

//--- logic/fetch_sequencer.sv
// One- and two-byte opcodes only; pages 0x10/0x11 and all unkept opcodes fetch as one-byte no-ops
`default_nettype none

module fetch_sequencer import cpu_core_pkg::*; (
  input  logic       clk,
  input  logic       reset_b,
  input  byte_t      din,
  input  logic       bus_busy,
  input  addr_t      lsu_addr,
  input  logic       vector_valid,
  input  addr_t      vector,
  input  cc_t        cc,
  output addr_t      addr,
  output inst_t      inst,
  output store_req_t store_req
);

  fetch_state_e state;
  fetch_state_e state_next;
  addr_t        pc;
  addr_t        pc_next;
  // Opcode held across the operand cycle
  byte_t        op_q;
  logic         two_byte;
  logic         is_branch;
  logic         is_store;
  logic         cond_base;
  logic         taken;
  addr_t        target;

  // ----------------------------------------
  // Classify the opcode on the bus
  // ----------------------------------------
  assign two_byte = (din[7:4] == ROW_BRANCH) || (din[7:4] == ROW_IMM_A) ||
                    (din[7:4] == ROW_IMM_B) || (din == OP_STA_DIR) || (din == OP_STB_DIR);

  assign is_branch = (op_q[7:4] == ROW_BRANCH);
  assign is_store  = (op_q == OP_STA_DIR) || (op_q == OP_STB_DIR);

  // 6809 table, odd conditions invert the even one
  always_comb begin
    case (op_q[3:1])
      3'd0:    cond_base = 1'b1;
      3'd1:    cond_base = ~(cc.c | cc.z);
      3'd2:    cond_base = ~cc.c;
      3'd3:    cond_base = ~cc.z;
      3'd4:    cond_base = ~cc.v;
      3'd5:    cond_base = ~cc.n;
      3'd6:    cond_base = ~(cc.n ^ cc.v);
      default: cond_base = ~(cc.z | (cc.n ^ cc.v));
    endcase
  end

  assign taken = is_branch && (cond_base ^ op_q[0]);

  // pc holds the operand address here
  assign target = pc + 16'd1 + {{8{din[7]}}, din};

  // LSU wins the bus when busy
  assign addr = bus_busy ? lsu_addr : pc;

  // ----------------------------------------
  // Next state and pc
  // ----------------------------------------
  always_comb begin
    state_next = state;
    pc_next    = pc;
    case (state)
      fetch_wait: begin
        if (vector_valid) begin
          state_next = fetch_ir;
          pc_next    = vector;
        end
      end
      fetch_ir: begin
        pc_next    = pc + 16'd1;
        state_next = two_byte ? fetch_operand : fetch_ir;
      end
      fetch_operand: begin
        pc_next    = taken ? target : pc + 16'd1;
        state_next = is_store ? fetch_store : fetch_ir;
      end
      fetch_store: state_next = fetch_ir;
      default:     state_next = fetch_wait;
    endcase
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      state     <= fetch_wait;
      pc        <= 16'h0000;
      inst      <= '0;
      store_req <= '0;
    end else begin
      state <= state_next;
      pc    <= pc_next;
      // Issue after the last byte of each instruction
      inst.valid   <= ((state == fetch_ir) && !two_byte) || (state == fetch_operand);
      inst.opcode  <= (state == fetch_ir) ? din : op_q;
      inst.operand <= (state == fetch_operand) ? din : 8'h00;
      // Store request lands in the fetch_store cycle
      store_req.valid  <= (state == fetch_operand) && is_store;
      store_req.src_b  <= (op_q == OP_STB_DIR);
      store_req.offset <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (state == fetch_ir) begin
      op_q <= din;
    end
  end

endmodule

`default_nettype wire

//--- logic/cpu_core.sv
// Memory must return din for the current addr in the same cycle; no wait states, no halt
`default_nettype none

module cpu_core import cpu_core_pkg::*; #(
  parameter addr_t VECTOR_ADDR = 16'hFFFE
) (
  input  logic  clk,
  input  logic  reset_b,
  input  byte_t din,
  output addr_t addr,
  output byte_t data_out,
  output logic  data_rw_n
);

  // LSU to fetch
  logic       bus_busy;
  addr_t      lsu_addr;
  logic       vector_valid;
  addr_t      vector;

  // Fetch to LSU and register file
  store_req_t store_req;
  inst_t      inst;

  // Register file back to the others
  byte_t      a_q;
  byte_t      b_q;
  cc_t        cc;

  load_store_unit #(
    .VECTOR_ADDR(VECTOR_ADDR)
  ) u_lsu (
    .clk         (clk),
    .reset_b     (reset_b),
    .din         (din),
    .store_req   (store_req),
    .a_q         (a_q),
    .b_q         (b_q),
    .bus_busy    (bus_busy),
    .lsu_addr    (lsu_addr),
    .vector_valid(vector_valid),
    .vector      (vector),
    .data_rw_n   (data_rw_n),
    .data_out    (data_out)
  );

  fetch_sequencer u_fetch (
    .clk         (clk),
    .reset_b     (reset_b),
    .din         (din),
    .bus_busy    (bus_busy),
    .lsu_addr    (lsu_addr),
    .vector_valid(vector_valid),
    .vector      (vector),
    .cc          (cc),
    .addr        (addr),
    .inst        (inst),
    .store_req   (store_req)
  );

  register_file u_regs (
    .clk    (clk),
    .reset_b(reset_b),
    .inst   (inst),
    .a_q    (a_q),
    .b_q    (b_q),
    .cc     (cc)
  );

endmodule

`default_nettype wire

//--- verif/cpu_core_checker.sv
// Reference model of the kept 6809 subset; assumes the vector at 0xFFFE and code never overwritten
`default_nettype none

module cpu_core_checker import cpu_core_pkg::*; (
  input  logic  clk,
  input  logic  reset_b,
  input  addr_t addr,
  input  byte_t data_out,
  input  logic  data_rw_n,
  input  byte_t image [0:65535],
  input  addr_t end_addr,
  output logic  done
);

  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [2:0] {
    m_vec_hi,
    m_vec_lo,
    m_ir,
    m_operand,
    m_store
  } model_state_e;

  model_state_e m_state;
  addr_t        m_pc;
  byte_t        m_a;
  byte_t        m_b;
  cc_t          m_cc;
  byte_t        vec_hi;
  byte_t        cur_op;
  byte_t        opd;
  // Instruction waiting for its issue cycle
  logic         pend;
  byte_t        pend_op;
  byte_t        pend_opd;
  logic         first_fetch;
  // Behavior that the last executed instruction belongs to
  int           last_kind;
  byte_t        st_off;
  logic         st_b;
  int           checks [1:5];
  int           errors [1:5];

  initial begin
    for (int k = 1; k <= 5; k++) begin
      checks[k] = 0;
      errors[k] = 0;
    end
  end

  task automatic compare_value(input int beh, input string name, input int expected,
                               input int actual);
    checks[beh]++;
    assert (expected == actual) else begin
      errors[beh]++;
      $display("Mismatch at %0t ns: %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  function automatic logic two_byte_op(input byte_t op);
    return (op[7:4] == 4'h2) || (op[7:4] == 4'h8) || (op[7:4] == 4'hC) ||
           (op == 8'h97) || (op == 8'hD7);
  endfunction

  // ----------------------------------------
  // Branch conditions, 6809 table
  // ----------------------------------------
  function automatic logic branch_taken(input logic [3:0] cond, input cc_t f);
    case (cond)
      4'h0: return 1'b1;
      4'h1: return 1'b0;
      4'h2: return !(f.c || f.z);
      4'h3: return f.c || f.z;
      4'h4: return !f.c;
      4'h5: return f.c;
      4'h6: return !f.z;
      4'h7: return f.z;
      4'h8: return !f.v;
      4'h9: return f.v;
      4'hA: return !f.n;
      4'hB: return f.n;
      4'hC: return !(f.n ^ f.v);
      4'hD: return f.n ^ f.v;
      4'hE: return !(f.z || (f.n ^ f.v));
      default: return f.z || (f.n ^ f.v);
    endcase
  endfunction

  // ----------------------------------------
  // Instruction semantics
  // ----------------------------------------
  task automatic exec_inst(input byte_t op, input byte_t arg);
    logic [3:0] row;
    logic [3:0] col;
    byte_t      r;
    byte_t      v;
    logic [8:0] t;
    logic [4:0] half;
    logic       cin;
    logic       keep;
    logic       wb;
    logic       hb;
    row  = op[7:4];
    col  = op[3:0];
    hb   = (row == 4'h5) || (row == 4'hC) || (op == 8'hD7);
    r    = hb ? m_b : m_a;
    v    = r;
    keep = 1'b1;
    wb   = 1'b1;
    last_kind = 5;
    if ((op == 8'h97) || (op == 8'hD7)) begin
      // Store sets flags as a load would
      wb     = 1'b0;
      m_cc.v = 1'b0;
    end else if ((row == 4'h8) || (row == 4'hC)) begin
      last_kind = 2;
      cin = (col == 4'h2 || col == 4'h9) ? m_cc.c : 1'b0;
      case (col)
        4'h0, 4'h1, 4'h2: begin
          t      = {1'b0, r} - {1'b0, arg} - {8'h00, cin};
          v      = t[7:0];
          m_cc.v = (r[7] != arg[7]) && (v[7] != r[7]);
          m_cc.c = t[8];
          wb     = (col != 4'h1);
        end
        4'h4, 4'h5: begin
          v      = r & arg;
          m_cc.v = 1'b0;
          wb     = (col != 4'h5);
        end
        4'h6: begin
          v      = arg;
          m_cc.v = 1'b0;
        end
        4'h8: begin
          v      = r ^ arg;
          m_cc.v = 1'b0;
        end
        4'hA: begin
          v      = r | arg;
          m_cc.v = 1'b0;
        end
        4'h9, 4'hB: begin
          t      = {1'b0, r} + {1'b0, arg} + {8'h00, cin};
          half   = {1'b0, r[3:0]} + {1'b0, arg[3:0]} + {4'h0, cin};
          v      = t[7:0];
          m_cc.h = half[4];
          m_cc.v = (r[7] == arg[7]) && (v[7] != r[7]);
          m_cc.c = t[8];
        end
        default: keep = 1'b0;
      endcase
    end else if ((row == 4'h4) || (row == 4'h5)) begin
      last_kind = 3;
      case (col)
        4'h0: begin
          v      = 8'h00 - r;
          m_cc.v = (r == 8'h80);
          m_cc.c = (r != 8'h00);
        end
        4'h3: begin
          v      = ~r;
          m_cc.v = 1'b0;
          m_cc.c = 1'b1;
        end
        4'h4: begin
          v      = r >> 1;
          m_cc.c = r[0];
        end
        4'h6: begin
          v      = {m_cc.c, r[7:1]};
          m_cc.c = r[0];
        end
        4'h7: begin
          v      = {r[7], r[7:1]};
          m_cc.c = r[0];
        end
        4'h8, 4'h9: begin
          v      = {r[6:0], (col == 4'h9) ? m_cc.c : 1'b0};
          m_cc.c = r[7];
          m_cc.v = v[7] ^ r[7];
        end
        4'hA: begin
          v      = r - 8'd1;
          m_cc.v = (r == 8'h80);
        end
        4'hC: begin
          v      = r + 8'd1;
          m_cc.v = (r == 8'h7F);
        end
        4'hD: begin
          m_cc.v = 1'b0;
          wb     = 1'b0;
        end
        4'hF: begin
          v      = 8'h00;
          m_cc.v = 1'b0;
          m_cc.c = 1'b0;
        end
        default: keep = 1'b0;
      endcase
    end else begin
      keep = 1'b0;
    end
    if (keep) begin
      m_cc.n = v[7];
      m_cc.z = (v == 8'h00);
      if (wb && hb) m_b = v;
      if (wb && !hb) m_a = v;
    end
  endtask

  // ----------------------------------------
  // Cycle model, checked mid-cycle
  // ----------------------------------------
  always @(negedge clk or negedge reset_b) begin
    if (!reset_b) begin
      m_state     = m_vec_hi;
      m_pc        = 16'h0000;
      m_a         = 8'h00;
      m_b         = 8'h00;
      m_cc        = 8'hD0;
      pend        = 1'b0;
      first_fetch = 1'b0;
      last_kind   = 5;
      done        = 1'b0;
    end else begin
      if (m_state != m_store) compare_value(5, "data_rw_n", 1, data_rw_n);
      case (m_state)
        m_vec_hi: begin
          compare_value(1, "addr", 16'hFFFE, addr);
          vec_hi  = image[16'hFFFE];
          m_state = m_vec_lo;
        end
        m_vec_lo: begin
          compare_value(1, "addr", 16'hFFFF, addr);
          m_pc        = {vec_hi, image[16'hFFFF]};
          first_fetch = 1'b1;
          m_state     = m_ir;
        end
        m_ir: begin
          if (pend) exec_inst(pend_op, pend_opd);
          pend = 1'b0;
          if (first_fetch) compare_value(1, "addr", 16'h1000, addr);
          else compare_value(4, "addr", m_pc, addr);
          first_fetch = 1'b0;
          if (m_pc == end_addr) done = 1'b1;
          cur_op = image[m_pc];
          m_pc   = m_pc + 16'd1;
          if (two_byte_op(cur_op)) begin
            m_state = m_operand;
          end else begin
            pend     = 1'b1;
            pend_op  = cur_op;
            pend_opd = 8'h00;
          end
        end
        m_operand: begin
          compare_value(4, "addr", m_pc, addr);
          opd = image[m_pc];
          // Target is relative to the byte after the operand
          if (cur_op[7:4] == 4'h2 && branch_taken(cur_op[3:0], m_cc))
            m_pc = m_pc + 16'd1 + {{8{opd[7]}}, opd};
          else
            m_pc = m_pc + 16'd1;
          pend     = 1'b1;
          pend_op  = cur_op;
          pend_opd = opd;
          st_off   = opd;
          st_b     = (cur_op == 8'hD7);
          m_state  = ((cur_op == 8'h97) || (cur_op == 8'hD7)) ? m_store : m_ir;
        end
        default: begin
          compare_value(5, "addr", {8'h00, st_off}, addr);
          compare_value(5, "data_rw_n", 0, data_rw_n);
          compare_value(last_kind, "data_out", st_b ? m_b : m_a, data_out);
          exec_inst(pend_op, pend_opd);
          pend    = 1'b0;
          m_state = m_ir;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_cpu_core.sv
// Random program at 0x1000 ends in a BRA-to-self loop; page zero is the only area written
`default_nettype none

module tb_cpu_core import cpu_core_pkg::*; ;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 16;
  localparam int ITEMS        = 48;
  localparam logic [3:0] IMM_COLS [10] = '{COL_SUB, COL_CMP, COL_SBC, COL_AND, COL_BIT,
                                           COL_LD, COL_EOR, COL_ADC, COL_OR, COL_ADD};
  localparam logic [3:0] INH_COLS [11] = '{COL_NEG, COL_COM, COL_LSR, COL_ROR, COL_ASR,
                                           COL_ASL, COL_ROL, COL_DEC, COL_INC, COL_TST,
                                           COL_CLR};

  logic        clk = 1'b0;
  logic        reset_b;
  byte_t       din;
  addr_t       addr;
  byte_t       data_out;
  logic        data_rw_n;
  byte_t       mem [0:65535];
  logic [15:0] lfsr = 16'd24986;
  addr_t       wr_ptr;
  addr_t       end_addr;
  int          prog_len = 0;
  logic        prog_done;

  always #4 clk = ~clk;

  cpu_core #(
    .VECTOR_ADDR(16'hFFFE)
  ) DUT (
    .clk      (clk),
    .reset_b  (reset_b),
    .din      (din),
    .addr     (addr),
    .data_out (data_out),
    .data_rw_n(data_rw_n)
  );

  cpu_core_checker u_checker (
    .clk      (clk),
    .reset_b  (reset_b),
    .addr     (addr),
    .data_out (data_out),
    .data_rw_n(data_rw_n),
    .image    (mem),
    .end_addr (end_addr),
    .done     (prog_done)
  );

  // ----------------------------------------
  // Memory, zero wait states
  // ----------------------------------------
  always @(posedge clk) begin
    if (reset_b && !data_rw_n) mem[addr] <= data_out;
    #1;
    din = mem[addr];
  end

  // Galois LFSR, taps for x^16+x^14+x^13+x^11+1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int value);
    value = 0;
    for (int k = 0; k < n; k++) begin
      value = (value << 1) | int'(lfsr[0]);
      lfsr  = lfsr_next(lfsr);
    end
  endtask

  task automatic put_byte(input byte_t b);
    mem[wr_ptr] = b;
    wr_ptr      = wr_ptr + 16'd1;
  endtask

  task automatic add_store(input int use_b);
    int off;
    take_bits(8, off);
    put_byte((use_b != 0) ? OP_STB_DIR : OP_STA_DIR);
    put_byte(off[7:0]);
  endtask

  // ----------------------------------------
  // Program image
  // ----------------------------------------
  task automatic build_program();
    int kind;
    int use_b;
    int sel;
    int val;
    for (int a = 0; a < 65536; a++) mem[a] = a[7:0] ^ a[15:8];
    mem[16'hFFFE] = 8'h10;
    mem[16'hFFFF] = 8'h00;
    wr_ptr = 16'h1000;
    for (int i = 0; i < ITEMS; i++) begin
      take_bits(2, kind);
      take_bits(1, use_b);
      take_bits(4, sel);
      case (kind)
        0: begin
          put_byte({(use_b != 0) ? ROW_IMM_B : ROW_IMM_A, IMM_COLS[sel % 10]});
          take_bits(8, val);
          put_byte(val[7:0]);
          add_store(use_b);
        end
        1: begin
          put_byte({(use_b != 0) ? ROW_INH_B : ROW_INH_A, INH_COLS[sel % 11]});
          add_store(use_b);
        end
        // Branch over a one-byte inherent op
        2: begin
          put_byte({ROW_BRANCH, sel[3:0]});
          put_byte(8'h01);
          take_bits(4, val);
          put_byte({(use_b != 0) ? ROW_INH_B : ROW_INH_A, INH_COLS[val % 11]});
        end
        default: add_store(use_b);
      endcase
    end
    // Final BRA to itself
    end_addr = wr_ptr;
    put_byte(8'h20);
    put_byte(8'hFE);
    prog_len = int'(wr_ptr - 16'h1000);
  endtask

  initial begin
    string names [1:5];
    int    total_checks;
    int    total_errors;
    names = '{"reset vector", "immediate ALU", "inherent ops", "branches and fetch",
              "store cycle"};
    total_checks = 0;
    total_errors = 0;
    reset_b = 1'b0;
    din     = 8'h00;
    build_program();
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset_b = 1'b1;
    wait (prog_done);
    repeat (4) @(posedge clk);
    for (int k = 1; k <= 5; k++) begin
      $display("%-20s checks %0d errors %0d", names[k], u_checker.checks[k],
               u_checker.errors[k]);
      total_checks += u_checker.checks[k];
      total_errors += u_checker.errors[k];
    end
    $display("Total: %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0 && total_checks > 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog, four cycles per program byte plus reset
  initial begin
    wait (prog_len != 0);
    #((prog_len * 4 + RESET_CYCLES) * 8);
    $display("Timeout: the program never reached its final loop");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

//--- cpu_core.f
logic/cpu_core_pkg.sv
logic/alu8.sv
logic/register_file.sv
logic/load_store_unit.sv
logic/fetch_sequencer.sv
logic/cpu_core.sv
verif/cpu_core_checker.sv
verif/tb_cpu_core.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the cpu_core testbench with Verilator, log goes to sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu_core \
  -f cpu_core.f -o sim_cpu_core \
  && ./obj_dir/sim_cpu_core > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0
